//--- source/cache_access_pkg.sv
`default_nettype none

package cache_access_pkg;

	localparam int NUM_EXECUTERS  = 4;
	localparam int LINE_HALFWORDS = 8; // halfwords per cache line

	typedef logic [25:0] way_addr_t;
	typedef logic [15:0] stack_addr_t;
	typedef logic [31:0] general_addr_t;
	typedef logic [5:0]  upper_addr_t; // nonzero means I/O space
	typedef logic [2:0]  stack_size_t; // in halfwords
	typedef logic [1:0]  exec_index_t;
	typedef logic [3:0]  exec_mask_t;
	typedef logic [1:0]  mask_type_t;

	// the executer number is held apart from the state
	typedef enum logic [2:0] {
		ST_IDLE,
		ST_STACK_FIRST,  // first lane of a line crossing stack access
		ST_STACK_SECOND, // second lane of the same access
		ST_STACK_SINGLE,
		ST_GENERAL,
		ST_FETCH
	} ctrl_state_t;

	localparam mask_type_t MASK_LANE_FIRST  = 2'd0;
	localparam mask_type_t MASK_LANE_SECOND = 2'd1;
	localparam mask_type_t MASK_GENERAL     = 2'd2;
	localparam mask_type_t MASK_FETCH       = 2'd3;

endpackage

`default_nettype wire

//--- source/access_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module access_arbiter (
	input  wire cache_access_pkg::exec_mask_t    stack_req,
	input  wire cache_access_pkg::exec_mask_t    general_req,
	input  wire cache_access_pkg::stack_addr_t   stack_addr0,
	input  wire cache_access_pkg::stack_addr_t   stack_addr1,
	input  wire cache_access_pkg::stack_addr_t   stack_addr2,
	input  wire cache_access_pkg::stack_addr_t   stack_addr3,
	input  wire cache_access_pkg::stack_size_t   stack_size0,
	input  wire cache_access_pkg::stack_size_t   stack_size1,
	input  wire cache_access_pkg::stack_size_t   stack_size2,
	input  wire cache_access_pkg::stack_size_t   stack_size3,
	input  wire cache_access_pkg::general_addr_t general_addr0,
	input  wire cache_access_pkg::general_addr_t general_addr1,
	input  wire cache_access_pkg::general_addr_t general_addr2,
	input  wire cache_access_pkg::general_addr_t general_addr3,
	input  wire                                  fetch_req,
	input  wire                                  allow_new,
	input  wire [2*cache_access_pkg::NUM_EXECUTERS:0] last_served,
	output cache_access_pkg::ctrl_state_t        next_kind,
	output cache_access_pkg::exec_index_t        next_index,
	output logic                                 next_valid,
	output cache_access_pkg::exec_mask_t         dependency_clear,
	output cache_access_pkg::stack_addr_t        next_stack_addr,
	output cache_access_pkg::stack_size_t        next_stack_size,
	output cache_access_pkg::general_addr_t      next_general_addr
);

	import cache_access_pkg::*;

	stack_addr_t              stack_addr [NUM_EXECUTERS];
	stack_size_t              stack_size [NUM_EXECUTERS];
	general_addr_t            general_addr [NUM_EXECUTERS];
	logic [2*NUM_EXECUTERS:0] req_vec; // stack and general interleaved with fetch on top
	logic [2*NUM_EXECUTERS:0] candidates;

	// a stack access whose last halfword runs past the line takes two lanes
	function automatic ctrl_state_t stack_kind(input stack_addr_t addr, input stack_size_t size);
		logic [3:0] line_end;
		line_end = {1'b0, addr[3:1]} + {1'b0, size};
		return (line_end > LINE_HALFWORDS) ? ST_STACK_FIRST : ST_STACK_SINGLE;
	endfunction

	assign stack_addr[0]   = stack_addr0;
	assign stack_addr[1]   = stack_addr1;
	assign stack_addr[2]   = stack_addr2;
	assign stack_addr[3]   = stack_addr3;
	assign stack_size[0]   = stack_size0;
	assign stack_size[1]   = stack_size1;
	assign stack_size[2]   = stack_size2;
	assign stack_size[3]   = stack_size3;
	assign general_addr[0] = general_addr0;
	assign general_addr[1] = general_addr1;
	assign general_addr[2] = general_addr2;
	assign general_addr[3] = general_addr3;

	always_comb begin
		for (int i = 0; i < NUM_EXECUTERS; i++) begin
			req_vec[2*i]   = stack_req[i];
			req_vec[2*i+1] = general_req[i];
		end
		req_vec[2*NUM_EXECUTERS] = fetch_req;
	end

	assign candidates = req_vec & ~last_served; // requester in its ack cycle still holds req

	// scan from lowest priority up so the highest one is written last
	always_comb begin
		next_valid = 1'b0;
		next_kind  = ST_IDLE;
		next_index = '0;
		if (allow_new) begin
			if (candidates[2*NUM_EXECUTERS]) begin
				next_valid = 1'b1;
				next_kind  = ST_FETCH;
			end
			for (int i = NUM_EXECUTERS - 1; i >= 0; i--) begin
				if (candidates[2*i+1]) begin
					next_valid = 1'b1;
					next_kind  = ST_GENERAL;
					next_index = exec_index_t'(i);
				end
				if (candidates[2*i]) begin
					next_valid = 1'b1;
					next_kind  = stack_kind(stack_addr[i], stack_size[i]);
					next_index = exec_index_t'(i);
				end
			end
		end
	end

	always_comb begin
		dependency_clear = '0;
		if (next_valid && next_kind != ST_FETCH)
			dependency_clear[next_index] = 1'b1; // fetch has no dependency to clear
	end

	assign next_stack_addr   = stack_addr[next_index];
	assign next_stack_size   = stack_size[next_index];
	assign next_general_addr = general_addr[next_index];

endmodule

`default_nettype wire

//--- source/access_state_reg.sv
`timescale 1ns/1ps
`default_nettype none

module access_state_reg (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire                                  advance,
	input  wire cache_access_pkg::ctrl_state_t   next_kind,
	input  wire cache_access_pkg::exec_index_t   next_index,
	input  wire                                  next_valid,
	input  wire cache_access_pkg::stack_addr_t   next_stack_addr,
	input  wire cache_access_pkg::stack_size_t   next_stack_size,
	input  wire cache_access_pkg::general_addr_t next_general_addr,
	input  wire cache_access_pkg::way_addr_t     fetch_addr,
	input  wire cache_access_pkg::exec_mask_t    stack_write,
	input  wire cache_access_pkg::exec_mask_t    general_write,
	input  wire cache_access_pkg::exec_mask_t    general_byte,
	output cache_access_pkg::ctrl_state_t        state,
	output cache_access_pkg::exec_index_t        exec_index,
	output cache_access_pkg::way_addr_t          way_addr,
	output cache_access_pkg::upper_addr_t        upper_addr,
	output cache_access_pkg::stack_size_t        stack_size_out,
	output logic                                 partial_write,
	output logic                                 byte_operation
);

	import cache_access_pkg::*;

	stack_addr_t second_lane_addr;

	// base plus 2*(size-1) on a held base whose bit 0 is already clear
	assign second_lane_addr = way_addr[15:0] + stack_addr_t'({stack_size_out - 3'd1, 1'b0});

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else if (advance) begin
			if (state == ST_STACK_FIRST)
				state <= ST_STACK_SECOND;
			else if (next_valid)
				state <= next_kind; // back to back when the arbiter found one
			else
				state <= ST_IDLE;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && state == ST_STACK_FIRST) begin
			way_addr[15:0] <= second_lane_addr;
		end else if (advance && next_valid) begin
			exec_index <= next_index;
			case (next_kind)
				ST_STACK_FIRST, ST_STACK_SINGLE: begin
					way_addr       <= way_addr_t'({next_stack_addr[15:1], 1'b0});
					upper_addr     <= '0;
					stack_size_out <= next_stack_size;
					partial_write  <= stack_write[next_index];
					byte_operation <= 1'b0;
				end
				ST_GENERAL: begin
					way_addr       <= next_general_addr[25:0];
					upper_addr     <= next_general_addr[31:26];
					stack_size_out <= '0;
					partial_write  <= general_write[next_index];
					byte_operation <= general_byte[next_index];
				end
				default: begin // instruction fetch is read only
					way_addr       <= {fetch_addr[25:1], 1'b0};
					upper_addr     <= '0;
					stack_size_out <= '0;
					partial_write  <= 1'b0;
					byte_operation <= 1'b0;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- source/cache_port_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cache_port_sequencer (
	input  wire cache_access_pkg::ctrl_state_t   state,
	input  wire cache_access_pkg::exec_index_t   exec_index,
	input  wire cache_access_pkg::upper_addr_t   upper_addr,
	input  wire                                  cache_fault,
	output cache_access_pkg::exec_mask_t         exec_ack,
	output logic                                 fetch_ack,
	output logic                                 lru_write,
	output logic                                 use_multi_access,
	output logic                                 no_write_override,
	output cache_access_pkg::mask_type_t         mask_type,
	output logic                                 allow_new,
	output logic [2*cache_access_pkg::NUM_EXECUTERS:0] last_served,
	output logic                                 advance
);

	import cache_access_pkg::*;

	logic io_access;
	logic complete;

	assign io_access = (upper_addr != '0);

	always_comb begin
		complete          = 1'b0;
		lru_write         = 1'b0;
		use_multi_access  = 1'b0;
		no_write_override = 1'b0;
		mask_type         = MASK_FETCH;
		last_served       = '0;
		advance           = 1'b0;
		case (state)
			ST_IDLE: begin
				advance = 1'b1; // picks up whatever the arbiter selects
			end
			ST_STACK_FIRST: begin
				use_multi_access           = 1'b1;
				mask_type                  = MASK_LANE_FIRST;
				last_served[{exec_index, 1'b0}] = 1'b1;
				if (!cache_fault) begin
					lru_write = 1'b1;
					advance   = 1'b1; // on to the second lane without an ack
				end
			end
			ST_STACK_SECOND: begin
				use_multi_access           = 1'b1;
				mask_type                  = MASK_LANE_SECOND;
				last_served[{exec_index, 1'b0}] = 1'b1;
				complete                   = !cache_fault;
				lru_write                  = !cache_fault;
			end
			ST_STACK_SINGLE: begin
				mask_type                  = MASK_LANE_FIRST;
				last_served[{exec_index, 1'b0}] = 1'b1;
				complete                   = !cache_fault;
				lru_write                  = !cache_fault;
			end
			ST_GENERAL: begin
				mask_type                  = MASK_GENERAL;
				last_served[{exec_index, 1'b1}] = 1'b1;
				if (io_access) begin
					// I/O is served outside the cache so the fault does not matter
					complete          = 1'b1;
					no_write_override = 1'b1;
				end else begin
					complete  = !cache_fault;
					lru_write = !cache_fault;
				end
			end
			ST_FETCH: begin
				mask_type                       = MASK_FETCH;
				last_served[2*NUM_EXECUTERS]    = 1'b1;
				complete                        = !cache_fault;
				lru_write                       = !cache_fault;
			end
			default: begin
				advance = 1'b1; // unused codes fall back to idle
			end
		endcase
		if (complete)
			advance = 1'b1;
	end

	assign allow_new = complete || (state == ST_IDLE);

	always_comb begin
		exec_ack  = '0;
		fetch_ack = 1'b0;
		if (complete) begin
			if (state == ST_FETCH)
				fetch_ack = 1'b1;
			else
				exec_ack[exec_index] = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/split_cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module split_cache_controller (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire cache_access_pkg::exec_mask_t    stack_req,
	input  wire cache_access_pkg::exec_mask_t    general_req,
	input  wire cache_access_pkg::exec_mask_t    stack_write,
	input  wire cache_access_pkg::exec_mask_t    general_write,
	input  wire cache_access_pkg::exec_mask_t    general_byte,
	input  wire cache_access_pkg::stack_addr_t   stack_addr0,
	input  wire cache_access_pkg::stack_addr_t   stack_addr1,
	input  wire cache_access_pkg::stack_addr_t   stack_addr2,
	input  wire cache_access_pkg::stack_addr_t   stack_addr3,
	input  wire cache_access_pkg::stack_size_t   stack_size0,
	input  wire cache_access_pkg::stack_size_t   stack_size1,
	input  wire cache_access_pkg::stack_size_t   stack_size2,
	input  wire cache_access_pkg::stack_size_t   stack_size3,
	input  wire cache_access_pkg::general_addr_t general_addr0,
	input  wire cache_access_pkg::general_addr_t general_addr1,
	input  wire cache_access_pkg::general_addr_t general_addr2,
	input  wire cache_access_pkg::general_addr_t general_addr3,
	input  wire                                  fetch_req,
	input  wire cache_access_pkg::way_addr_t     fetch_addr,
	input  wire                                  cache_fault,
	output cache_access_pkg::exec_mask_t         exec_ack,
	output logic                                 fetch_ack,
	output logic                                 lru_write,
	output logic                                 use_multi_access,
	output logic                                 no_write_override,
	output cache_access_pkg::mask_type_t         mask_type,
	output cache_access_pkg::exec_mask_t         dependency_clear,
	output cache_access_pkg::way_addr_t          way_addr,
	output cache_access_pkg::upper_addr_t        upper_addr,
	output cache_access_pkg::exec_index_t        exec_index,
	output cache_access_pkg::stack_size_t        stack_size_out,
	output logic                                 partial_write,
	output logic                                 byte_operation
);

	import cache_access_pkg::*;

	ctrl_state_t              state;
	ctrl_state_t              next_kind;
	exec_index_t              next_index;
	logic                     next_valid;
	stack_addr_t              next_stack_addr;
	stack_size_t              next_stack_size;
	general_addr_t            next_general_addr;
	logic                     allow_new;
	logic [2*NUM_EXECUTERS:0] last_served;
	logic                     advance;

	access_arbiter u_arbiter (
		.stack_req         (stack_req),
		.general_req       (general_req),
		.stack_addr0       (stack_addr0),
		.stack_addr1       (stack_addr1),
		.stack_addr2       (stack_addr2),
		.stack_addr3       (stack_addr3),
		.stack_size0       (stack_size0),
		.stack_size1       (stack_size1),
		.stack_size2       (stack_size2),
		.stack_size3       (stack_size3),
		.general_addr0     (general_addr0),
		.general_addr1     (general_addr1),
		.general_addr2     (general_addr2),
		.general_addr3     (general_addr3),
		.fetch_req         (fetch_req),
		.allow_new         (allow_new),
		.last_served       (last_served),
		.next_kind         (next_kind),
		.next_index        (next_index),
		.next_valid        (next_valid),
		.dependency_clear  (dependency_clear),
		.next_stack_addr   (next_stack_addr),
		.next_stack_size   (next_stack_size),
		.next_general_addr (next_general_addr)
	);

	access_state_reg u_state_reg (
		.clk               (clk),
		.rst_n             (rst_n),
		.advance           (advance),
		.next_kind         (next_kind),
		.next_index        (next_index),
		.next_valid        (next_valid),
		.next_stack_addr   (next_stack_addr),
		.next_stack_size   (next_stack_size),
		.next_general_addr (next_general_addr),
		.fetch_addr        (fetch_addr),
		.stack_write       (stack_write),
		.general_write     (general_write),
		.general_byte      (general_byte),
		.state             (state),
		.exec_index        (exec_index),
		.way_addr          (way_addr),
		.upper_addr        (upper_addr),
		.stack_size_out    (stack_size_out),
		.partial_write     (partial_write),
		.byte_operation    (byte_operation)
	);

	cache_port_sequencer u_sequencer (
		.state             (state),
		.exec_index        (exec_index),
		.upper_addr        (upper_addr),
		.cache_fault       (cache_fault),
		.exec_ack          (exec_ack),
		.fetch_ack         (fetch_ack),
		.lru_write         (lru_write),
		.use_multi_access  (use_multi_access),
		.no_write_override (no_write_override),
		.mask_type         (mask_type),
		.allow_new         (allow_new),
		.last_served       (last_served),
		.advance           (advance)
	);

endmodule

`default_nettype wire

//--- testbench/tb_split_cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_split_cache_controller;

	import cache_access_pkg::*;

	localparam int MAX_ENTRIES = 64;

	logic          clk;
	logic          rst_n;
	exec_mask_t    stack_req;
	exec_mask_t    general_req;
	exec_mask_t    stack_write;
	exec_mask_t    general_write;
	exec_mask_t    general_byte;
	stack_addr_t   s_addr [NUM_EXECUTERS];
	stack_size_t   s_size [NUM_EXECUTERS];
	general_addr_t g_addr [NUM_EXECUTERS];
	logic          fetch_req;
	way_addr_t     fetch_addr;
	logic          cache_fault;
	exec_mask_t    exec_ack;
	logic          fetch_ack;
	logic          lru_write;
	logic          use_multi_access;
	logic          no_write_override;
	mask_type_t    mask_type;
	exec_mask_t    dependency_clear;
	way_addr_t     way_addr;
	upper_addr_t   upper_addr;
	exec_index_t   exec_index;
	stack_size_t   stack_size_out;
	logic          partial_write;
	logic          byte_operation;

	// one golden line per access
	int            e_group [MAX_ENTRIES];
	int            e_kind [MAX_ENTRIES]; // 0 stack, 1 general, 2 fetch
	exec_index_t   e_idx [MAX_ENTRIES];
	general_addr_t e_addr [MAX_ENTRIES];
	stack_size_t   e_size [MAX_ENTRIES];
	way_addr_t     e_way [MAX_ENTRIES];
	way_addr_t     e_second [MAX_ENTRIES];
	mask_type_t    e_mask [MAX_ENTRIES];
	logic          e_two [MAX_ENTRIES];
	logic          e_io [MAX_ENTRIES];

	int   n_entries = 0;
	int   errors    = 0;
	int   served    = 0;
	int   cycles    = 0;
	int   drop_k    = -1; // access acked last whose request goes low next
	logic loaded    = 1'b0;

	split_cache_controller dut (
		.stack_addr0   (s_addr[0]),
		.stack_addr1   (s_addr[1]),
		.stack_addr2   (s_addr[2]),
		.stack_addr3   (s_addr[3]),
		.stack_size0   (s_size[0]),
		.stack_size1   (s_size[1]),
		.stack_size2   (s_size[2]),
		.stack_size3   (s_size[3]),
		.general_addr0 (g_addr[0]),
		.general_addr1 (g_addr[1]),
		.general_addr2 (g_addr[2]),
		.general_addr3 (g_addr[3]),
		.*
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic check_addr(input way_addr_t got, input way_addr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_upper(input upper_addr_t got, input upper_addr_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_index(input exec_index_t got, input exec_index_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_mask(input mask_type_t got, input mask_type_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_exec(input exec_mask_t got, input exec_mask_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_size(input stack_size_t got, input stack_size_t exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// executer whose dependency clears when access k gets selected
	function automatic exec_mask_t dep_for(input int k, input int last);
		if (k > last || e_kind[k] == 2)
			return '0;
		return exec_mask_t'(1) << e_idx[k];
	endfunction

	function automatic int draw_faults(input int k);
		return e_io[k] ? 3 : int'($urandom % 4); // I/O sees the fault held high
	endfunction

	// write and byte flags follow the access number
	function automatic logic write_flag(input int k);
		return k[0];
	endfunction

	function automatic logic byte_flag(input int k);
		return k[1];
	endfunction

	task automatic set_request(input int k, input logic on);
		case (e_kind[k])
			0: begin
				stack_req[e_idx[k]]   = on;
				stack_write[e_idx[k]] = on && write_flag(k);
				s_addr[e_idx[k]]      = e_addr[k][15:0];
				s_size[e_idx[k]]      = e_size[k];
			end
			1: begin
				general_req[e_idx[k]]   = on;
				general_write[e_idx[k]] = on && write_flag(k);
				general_byte[e_idx[k]]  = on && byte_flag(k);
				g_addr[e_idx[k]]        = e_addr[k];
			end
			default: begin
				fetch_req  = on;
				fetch_addr = e_addr[k][25:0];
			end
		endcase
	endtask

	task automatic drop_served();
		if (drop_k >= 0)
			set_request(drop_k, 1'b0);
		drop_k = -1;
	endtask

	// raise a whole group at once and expect the acks in file order
	task automatic serve_group(input int first, input int last);
		int   p;
		int   lane;
		int   fault_left;
		logic exp_ack;
		logic got_ack;
		@(negedge clk);
		drop_served();
		for (int k = first; k <= last; k++)
			set_request(k, 1'b1);
		cache_fault = 1'b0;
		#40;
		check_exec(exec_ack, '0, "exec_ack while idle");
		check_flag(fetch_ack, 1'b0, "fetch_ack while idle");
		check_exec(dependency_clear, dep_for(first, last), "dependency_clear from idle");
		p          = first;
		lane       = 0;
		fault_left = draw_faults(first);
		while (p <= last) begin
			@(negedge clk);
			drop_served();
			cache_fault = (fault_left != 0);
			#40;
			exp_ack = (e_io[p] || !cache_fault) && (!e_two[p] || lane == 1);
			check_addr(way_addr, (lane == 1) ? e_second[p] : e_way[p], "way_addr");
			check_upper(upper_addr, (e_kind[p] == 1) ? e_addr[p][31:26] : '0, "upper_addr");
			check_mask(mask_type, (lane == 1) ? MASK_LANE_SECOND : e_mask[p], "mask_type");
			if (e_kind[p] != 2)
				check_index(exec_index, e_idx[p], "exec_index");
			check_size(stack_size_out, (e_kind[p] == 0) ? e_size[p] : '0, "stack_size_out");
			check_flag(partial_write, (e_kind[p] != 2) && write_flag(p), "partial_write");
			check_flag(byte_operation, (e_kind[p] == 1) && byte_flag(p), "byte_operation");
			check_flag(use_multi_access, e_two[p], "use_multi_access");
			check_flag(no_write_override, e_io[p], "no_write_override");
			check_flag(lru_write, !cache_fault && !e_io[p], "lru_write");
			check_flag(fetch_ack, exp_ack && e_kind[p] == 2, "fetch_ack");
			check_exec(exec_ack, (exp_ack && e_kind[p] != 2) ? exec_mask_t'(1) << e_idx[p] : '0,
				"exec_ack");
			check_exec(dependency_clear, exp_ack ? dep_for(p + 1, last) : '0, "dependency_clear");
			got_ack = (e_kind[p] == 2) ? fetch_ack : exec_ack[e_idx[p]];
			if (cache_fault && fault_left > 0)
				fault_left--;
			if (got_ack) begin
				served++;
				drop_k     = p;
				p++;
				lane       = 0;
				fault_left = (p <= last) ? draw_faults(p) : 0;
			end else if (e_two[p] && lane == 0 && !cache_fault) begin
				lane       = 1; // first lane done without an ack
				fault_left = draw_faults(p);
			end
		end
	endtask

	initial begin
		wait (loaded);
		while (cycles <= 20 * n_entries) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped acknowledging", cycles);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int    fd;
		string line;
		int    first;
		int    last;
		void'($urandom(32'h22dd));
		rst_n         = 1'b0;
		stack_req     = '1; // held through reset and must not be served
		general_req   = '0;
		stack_write   = '0;
		general_write = '0;
		general_byte  = '0;
		fetch_req     = 1'b0;
		fetch_addr    = '0;
		cache_fault   = 1'b0;
		for (int i = 0; i < NUM_EXECUTERS; i++) begin
			s_addr[i] = '0;
			s_size[i] = '0;
			g_addr[i] = '0;
		end
		fd = $fopen("testbench/access_golden.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("cannot open testbench/access_golden.txt");
		end else begin
			while (!$feof(fd) && n_entries < MAX_ENTRIES) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 0 && line.getc(0) != "#" && $sscanf(line,
						"%d %d %d %h %d %h %h %d %d %d", e_group[n_entries], e_kind[n_entries],
						e_idx[n_entries], e_addr[n_entries], e_size[n_entries], e_way[n_entries],
						e_second[n_entries], e_mask[n_entries], e_two[n_entries],
						e_io[n_entries]) == 10)
					n_entries++;
			end
			$fclose(fd);
		end
		loaded = 1'b1;
		repeat (10) begin
			@(negedge clk);
			check_exec(exec_ack, '0, "exec_ack in reset");
			check_flag(fetch_ack, 1'b0, "fetch_ack in reset");
			check_flag(lru_write, 1'b0, "lru_write in reset");
		end
		stack_req = '0;
		rst_n     = 1'b1;
		first     = 0;
		while (first < n_entries) begin
			last = first;
			while (last + 1 < n_entries && e_group[last + 1] == e_group[first])
				last++;
			serve_group(first, last);
			first = last + 1;
		end
		$display("errors: %0d, accesses served: %0d of %0d", errors, served, n_entries);
		if (errors == 0 && n_entries > 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/access_golden.txt
# group kind(0 stack 1 general 2 fetch) exec addr size way_addr second_lane mask_type two_lane io
# lines of one group are raised together and listed in priority order, hex for the addresses
1 0 0 00001234 2 0001234 0000000 0 0 0
2 0 1 00002a37 3 0002a36 0000000 0 0 0
3 0 2 00000100 7 0000100 0000000 0 0 0
4 0 3 0000fff2 1 000fff2 0000000 0 0 0
5 0 0 0000004c 4 000004c 0000052 0 1 0
6 0 2 00007ffe 7 0007ffe 000800a 0 1 0
7 1 1 00abcdef 0 0abcdef 0000000 2 0 0
8 1 3 fc000010 0 0000010 0000000 2 0 1
9 2 0 03ffffff 0 3fffffe 0000000 3 0 0
10 1 0 01000000 0 1000000 0000000 2 0 0
10 0 1 00000030 2 0000030 0000000 0 0 0
10 1 1 00000080 0 0000080 0000000 2 0 0
10 1 3 00000400 0 0000400 0000000 2 0 0
10 2 0 00000201 0 0000200 0000000 3 0 0
11 0 2 000000fa 5 00000fa 0000102 0 1 0
11 1 2 40000000 0 0000000 0000000 2 0 1

//--- build.f
source/cache_access_pkg.sv
source/access_arbiter.sv
source/access_state_reg.sv
source/cache_port_sequencer.sv
source/split_cache_controller.sv
testbench/tb_split_cache_controller.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module tb_split_cache_controller -f build.f -o tb_split_cache_controller
./obj_dir/tb_split_cache_controller > sim.log
cat sim.log
if grep -q "Simulation failed" sim.log; then
	exit 1
fi
echo "no failure reported in sim.log"
